// ==== verilog/mips_isa_pkg.sv ====
package mips_isa_pkg;

    localparam int INST_W = 32;

    // field positions
    localparam int OP_LSB    = 26;
    localparam int OP_W      = 6;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int SHAMT_W   = 5;
    localparam int FUNCT_LSB = 0;
    localparam int FUNCT_W   = 6;
    localparam int IMM_LSB   = 0;
    localparam int IMM_W     = 16;

    // primary opcodes
    localparam logic [OP_W-1:0] OP_SPECIAL = 6'b000000;
    localparam logic [OP_W-1:0] OP_ADDI    = 6'b001000;
    localparam logic [OP_W-1:0] OP_ADDIU   = 6'b001001;
    localparam logic [OP_W-1:0] OP_SLTI    = 6'b001010;
    localparam logic [OP_W-1:0] OP_SLTIU   = 6'b001011;
    localparam logic [OP_W-1:0] OP_ANDI    = 6'b001100;
    localparam logic [OP_W-1:0] OP_ORI     = 6'b001101;
    localparam logic [OP_W-1:0] OP_XORI    = 6'b001110;
    localparam logic [OP_W-1:0] OP_LUI     = 6'b001111;
    localparam logic [OP_W-1:0] OP_PREF    = 6'b110011;

    // SPECIAL function codes
    localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [FUNCT_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [FUNCT_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [FUNCT_W-1:0] FN_SYNC = 6'b001111;
    localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [FUNCT_W-1:0] FN_SLTU = 6'b101011;

endpackage

// ==== verilog/mips_ctrl_pkg.sv ====
package mips_ctrl_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // operation codes seen by the execute stage
    typedef enum logic [7:0] {
        ALU_NOP   = 8'b0000_0000,
        ALU_SRL   = 8'b0000_0010,
        ALU_SRA   = 8'b0000_0011,
        ALU_ADD   = 8'b0010_0000,
        ALU_ADDU  = 8'b0010_0001,
        ALU_SUB   = 8'b0010_0010,
        ALU_SUBU  = 8'b0010_0011,
        ALU_AND   = 8'b0010_0100,
        ALU_OR    = 8'b0010_0101,
        ALU_XOR   = 8'b0010_0110,
        ALU_NOR   = 8'b0010_0111,
        ALU_SLT   = 8'b0010_1010,
        ALU_SLTU  = 8'b0010_1011,
        ALU_ADDI  = 8'b0101_0101,
        ALU_ADDIU = 8'b0101_0110,
        ALU_SLL   = 8'b0111_1100
    } alu_op_e;

    // result class, picks the execute result mux
    typedef enum logic [2:0] {
        SEL_NOP   = 3'b000,
        SEL_LOGIC = 3'b001,
        SEL_SHIFT = 3'b010,
        SEL_ARITH = 3'b100
    } alu_sel_e;

endpackage

// ==== verilog/decode_if.sv ====
`timescale 1ns/1ns

interface decode_if;

    logic                     rd1_en;
    logic                     rd2_en;
    mips_ctrl_pkg::reg_addr_t rd1_addr;
    mips_ctrl_pkg::reg_addr_t rd2_addr;
    mips_ctrl_pkg::word_t     imm;
    mips_ctrl_pkg::alu_op_e   aluop;
    mips_ctrl_pkg::alu_sel_e  alusel;
    mips_ctrl_pkg::reg_addr_t wd;
    logic                     wreg;
    logic                     inst_invalid;
    logic                     valid;

    modport decoder (
        output rd1_en, rd2_en, rd1_addr, rd2_addr, imm,
        output aluop, alusel, wd, wreg, inst_invalid, valid
    );

    modport operand (
        input rd1_en, rd2_en, rd1_addr, rd2_addr, imm,
        input aluop, alusel, wd, wreg, inst_invalid, valid
    );

endinterface

// ==== verilog/rf_read_if.sv ====
`timescale 1ns/1ns

interface rf_read_if;

    logic                     rd1_en;
    logic                     rd2_en;
    mips_ctrl_pkg::reg_addr_t rd1_addr;
    mips_ctrl_pkg::reg_addr_t rd2_addr;
    mips_ctrl_pkg::word_t     rd1_data;  // zero when port disabled
    mips_ctrl_pkg::word_t     rd2_data;

    modport decoder (
        output rd1_en, rd2_en, rd1_addr, rd2_addr,
        input  rd1_data, rd2_data
    );

    modport regfile (
        input  rd1_en, rd2_en, rd1_addr, rd2_addr,
        output rd1_data, rd2_data
    );

endinterface

// ==== verilog/mips_regfile.sv ====
`timescale 1ns/1ns

module mips_regfile (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    rf_read_if.regfile               rd,
    input  logic                     wb_we_i,
    input  mips_ctrl_pkg::reg_addr_t wb_waddr_i,
    input  mips_ctrl_pkg::word_t     wb_wdata_i
);

    mips_ctrl_pkg::word_t regs [32];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (wb_we_i && (wb_waddr_i != '0)) begin  // r0 stays zero
            regs[wb_waddr_i] <= wb_wdata_i;
        end
    end

    function automatic mips_ctrl_pkg::word_t read_port(
        input logic                     en,
        input mips_ctrl_pkg::reg_addr_t addr
    );
        if (!en || (addr == '0)) begin
            return '0;
        end
        if (wb_we_i && (wb_waddr_i == addr)) begin
            return wb_wdata_i;  // same-cycle bypass
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd.rd1_data = read_port(rd.rd1_en, rd.rd1_addr);
        rd.rd2_data = read_port(rd.rd2_en, rd.rd2_addr);
    end

    // decoder only raises a strobe with a held, known instruction
    a_rd_data_known: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown({rd.rd1_data, rd.rd2_data})
    );

endmodule

// ==== verilog/mips_decoder.sv ====
`timescale 1ns/1ns

module mips_decoder (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [mips_isa_pkg::INST_W-1:0] inst_i,
    input  logic                            inst_valid_i,
    rf_read_if.decoder                      rd,
    decode_if.decoder                       dec
);

    logic [mips_isa_pkg::INST_W-1:0]  inst_q;
    logic                             inst_valid_q;

    logic [mips_isa_pkg::OP_W-1:0]    op_f;
    logic [mips_isa_pkg::FUNCT_W-1:0] funct_f;
    logic [mips_isa_pkg::SHAMT_W-1:0] shamt_f;
    logic [mips_isa_pkg::IMM_W-1:0]   imm_f;
    mips_ctrl_pkg::reg_addr_t         rs_f;
    mips_ctrl_pkg::reg_addr_t         rt_f;
    mips_ctrl_pkg::reg_addr_t         rd_f;

    logic                             rd1_en;
    logic                             rd2_en;
    logic                             wreg;
    logic                             known;
    mips_ctrl_pkg::reg_addr_t         wd;
    mips_ctrl_pkg::word_t             imm;
    mips_ctrl_pkg::alu_op_e           aluop;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        inst_q <= inst_i;
    end

    assign op_f    = inst_q[mips_isa_pkg::OP_LSB +: mips_isa_pkg::OP_W];
    assign rs_f    = inst_q[mips_isa_pkg::RS_LSB +: mips_ctrl_pkg::REG_ADDR_W];
    assign rt_f    = inst_q[mips_isa_pkg::RT_LSB +: mips_ctrl_pkg::REG_ADDR_W];
    assign rd_f    = inst_q[mips_isa_pkg::RD_LSB +: mips_ctrl_pkg::REG_ADDR_W];
    assign shamt_f = inst_q[mips_isa_pkg::SHAMT_LSB +: mips_isa_pkg::SHAMT_W];
    assign funct_f = inst_q[mips_isa_pkg::FUNCT_LSB +: mips_isa_pkg::FUNCT_W];
    assign imm_f   = inst_q[mips_isa_pkg::IMM_LSB +: mips_isa_pkg::IMM_W];

    function automatic mips_ctrl_pkg::alu_sel_e sel_of(input mips_ctrl_pkg::alu_op_e op);
        case (op)
            mips_ctrl_pkg::ALU_NOP: return mips_ctrl_pkg::SEL_NOP;
            mips_ctrl_pkg::ALU_OR,
            mips_ctrl_pkg::ALU_AND,
            mips_ctrl_pkg::ALU_XOR,
            mips_ctrl_pkg::ALU_NOR: return mips_ctrl_pkg::SEL_LOGIC;
            mips_ctrl_pkg::ALU_SLL,
            mips_ctrl_pkg::ALU_SRL,
            mips_ctrl_pkg::ALU_SRA: return mips_ctrl_pkg::SEL_SHIFT;
            default:                return mips_ctrl_pkg::SEL_ARITH;
        endcase
    endfunction

    always_comb begin
        aluop  = mips_ctrl_pkg::ALU_NOP;
        rd1_en = 1'b0;
        rd2_en = 1'b0;
        wreg   = 1'b0;
        known  = 1'b0;
        wd     = rd_f;
        imm    = '0;
        case (op_f)
            mips_isa_pkg::OP_SPECIAL: begin
                rd1_en = 1'b1;
                rd2_en = 1'b1;
                wreg   = 1'b1;
                known  = (shamt_f == '0);
                case (funct_f)
                    mips_isa_pkg::FN_OR:   aluop = mips_ctrl_pkg::ALU_OR;
                    mips_isa_pkg::FN_AND:  aluop = mips_ctrl_pkg::ALU_AND;
                    mips_isa_pkg::FN_XOR:  aluop = mips_ctrl_pkg::ALU_XOR;
                    mips_isa_pkg::FN_NOR:  aluop = mips_ctrl_pkg::ALU_NOR;
                    mips_isa_pkg::FN_SLLV,
                    mips_isa_pkg::FN_SLL:  aluop = mips_ctrl_pkg::ALU_SLL;
                    mips_isa_pkg::FN_SRLV,
                    mips_isa_pkg::FN_SRL:  aluop = mips_ctrl_pkg::ALU_SRL;
                    mips_isa_pkg::FN_SRAV,
                    mips_isa_pkg::FN_SRA:  aluop = mips_ctrl_pkg::ALU_SRA;
                    mips_isa_pkg::FN_SLT:  aluop = mips_ctrl_pkg::ALU_SLT;
                    mips_isa_pkg::FN_SLTU: aluop = mips_ctrl_pkg::ALU_SLTU;
                    mips_isa_pkg::FN_ADD:  aluop = mips_ctrl_pkg::ALU_ADD;
                    mips_isa_pkg::FN_ADDU: aluop = mips_ctrl_pkg::ALU_ADDU;
                    mips_isa_pkg::FN_SUB:  aluop = mips_ctrl_pkg::ALU_SUB;
                    mips_isa_pkg::FN_SUBU: aluop = mips_ctrl_pkg::ALU_SUBU;
                    mips_isa_pkg::FN_SYNC: begin
                        rd1_en = 1'b0;  // only rt is looked at
                        wreg   = 1'b0;
                    end
                    default:               known = 1'b0;
                endcase
                if (funct_f inside {mips_isa_pkg::FN_SLL, mips_isa_pkg::FN_SRL,
                                    mips_isa_pkg::FN_SRA}) begin
                    rd1_en = 1'b0;  // shamt replaces rs
                    imm    = {{(mips_ctrl_pkg::WORD_W - mips_isa_pkg::SHAMT_W){1'b0}}, shamt_f};
                    known  = (rs_f == '0);
                end
            end
            mips_isa_pkg::OP_ORI,
            mips_isa_pkg::OP_LUI:   aluop = mips_ctrl_pkg::ALU_OR;
            mips_isa_pkg::OP_ANDI:  aluop = mips_ctrl_pkg::ALU_AND;
            mips_isa_pkg::OP_XORI:  aluop = mips_ctrl_pkg::ALU_XOR;
            mips_isa_pkg::OP_SLTI:  aluop = mips_ctrl_pkg::ALU_SLT;
            mips_isa_pkg::OP_SLTIU: aluop = mips_ctrl_pkg::ALU_SLTU;
            mips_isa_pkg::OP_ADDI:  aluop = mips_ctrl_pkg::ALU_ADDI;
            mips_isa_pkg::OP_ADDIU: aluop = mips_ctrl_pkg::ALU_ADDIU;
            mips_isa_pkg::OP_PREF:  known = 1'b1;  // hint only
            default:                known = 1'b0;
        endcase

        // immediate forms, rs op imm -> rt
        if ((op_f != mips_isa_pkg::OP_SPECIAL) && (aluop != mips_ctrl_pkg::ALU_NOP)) begin
            known  = 1'b1;
            rd1_en = 1'b1;
            wreg   = 1'b1;
            wd     = rt_f;
            case (op_f)
                mips_isa_pkg::OP_ORI,
                mips_isa_pkg::OP_ANDI,
                mips_isa_pkg::OP_XORI: imm = {16'h0, imm_f};
                mips_isa_pkg::OP_LUI:  imm = {imm_f, 16'h0};
                default:               imm = {{16{imm_f[15]}}, imm_f};
            endcase
        end

        if (!known || !inst_valid_q) begin
            aluop  = mips_ctrl_pkg::ALU_NOP;
            rd1_en = 1'b0;
            rd2_en = 1'b0;
            wreg   = 1'b0;
            wd     = '0;
            imm    = '0;
        end
    end

    assign rd.rd1_en        = rd1_en;
    assign rd.rd2_en        = rd2_en;
    assign rd.rd1_addr      = rs_f;
    assign rd.rd2_addr      = rt_f;

    assign dec.rd1_en       = rd1_en;
    assign dec.rd2_en       = rd2_en;
    assign dec.rd1_addr     = rs_f;
    assign dec.rd2_addr     = rt_f;
    assign dec.imm          = imm;
    assign dec.aluop        = aluop;
    assign dec.alusel       = sel_of(aluop);
    assign dec.wd           = wd;
    assign dec.wreg         = wreg;
    assign dec.inst_invalid = inst_valid_q && !known;
    assign dec.valid        = inst_valid_q;

    a_wreg_not_invalid: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        dec.wreg |-> dec.valid && !dec.inst_invalid
    );

endmodule

// ==== verilog/mips_operand_stage.sv ====
`timescale 1ns/1ns

module mips_operand_stage (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    decode_if.operand                 dec,
    input  mips_ctrl_pkg::word_t      rd1_data_i,
    input  mips_ctrl_pkg::word_t      rd2_data_i,
    input  logic                      ex_wreg_i,
    input  mips_ctrl_pkg::reg_addr_t  ex_wd_i,
    input  mips_ctrl_pkg::word_t      ex_wdata_i,
    input  logic                      mem_wreg_i,
    input  mips_ctrl_pkg::reg_addr_t  mem_wd_i,
    input  mips_ctrl_pkg::word_t      mem_wdata_i,
    output mips_ctrl_pkg::alu_op_e    aluop_o,
    output mips_ctrl_pkg::alu_sel_e   alusel_o,
    output mips_ctrl_pkg::word_t      reg1_o,
    output mips_ctrl_pkg::word_t      reg2_o,
    output mips_ctrl_pkg::reg_addr_t  wd_o,
    output logic                      wreg_o,
    output logic                      inst_invalid_o,
    output logic                      valid_o
);

    mips_ctrl_pkg::word_t reg1_d;
    mips_ctrl_pkg::word_t reg2_d;

    // ex beats mem beats regfile, r0 not excluded
    function automatic mips_ctrl_pkg::word_t pick(
        input logic                     en,
        input mips_ctrl_pkg::reg_addr_t addr,
        input mips_ctrl_pkg::word_t     rf_data,
        input mips_ctrl_pkg::word_t     imm
    );
        if (!en) begin
            return imm;
        end
        if (ex_wreg_i && (ex_wd_i == addr)) begin
            return ex_wdata_i;
        end
        if (mem_wreg_i && (mem_wd_i == addr)) begin
            return mem_wdata_i;
        end
        return rf_data;
    endfunction

    always_comb begin
        reg1_d = pick(dec.rd1_en, dec.rd1_addr, rd1_data_i, dec.imm);
        reg2_d = pick(dec.rd2_en, dec.rd2_addr, rd2_data_i, dec.imm);
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            aluop_o        <= mips_ctrl_pkg::ALU_NOP;
            alusel_o       <= mips_ctrl_pkg::SEL_NOP;
            reg1_o         <= '0;
            reg2_o         <= '0;
            wd_o           <= '0;
            wreg_o         <= 1'b0;
            inst_invalid_o <= 1'b0;
            valid_o        <= 1'b0;
        end else begin
            aluop_o        <= dec.aluop;
            alusel_o       <= dec.alusel;
            reg1_o         <= reg1_d;
            reg2_o         <= reg2_d;
            wd_o           <= dec.wd;
            wreg_o         <= dec.wreg;
            inst_invalid_o <= dec.inst_invalid;
            valid_o        <= dec.valid;
        end
    end

endmodule

// ==== verilog/mips_id_top.sv ====
`timescale 1ns/1ns

module mips_id_top (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [mips_isa_pkg::INST_W-1:0] inst_i,
    input  logic                            inst_valid_i,
    input  logic                            wb_we_i,
    input  mips_ctrl_pkg::reg_addr_t        wb_waddr_i,
    input  mips_ctrl_pkg::word_t            wb_wdata_i,
    input  logic                            ex_wreg_i,
    input  mips_ctrl_pkg::reg_addr_t        ex_wd_i,
    input  mips_ctrl_pkg::word_t            ex_wdata_i,
    input  logic                            mem_wreg_i,
    input  mips_ctrl_pkg::reg_addr_t        mem_wd_i,
    input  mips_ctrl_pkg::word_t            mem_wdata_i,
    output mips_ctrl_pkg::alu_op_e          aluop_o,
    output mips_ctrl_pkg::alu_sel_e         alusel_o,
    output mips_ctrl_pkg::word_t            reg1_o,
    output mips_ctrl_pkg::word_t            reg2_o,
    output mips_ctrl_pkg::reg_addr_t        wd_o,
    output logic                            wreg_o,
    output logic                            inst_invalid_o,
    output logic                            valid_o
);

    rf_read_if rf_rd ();
    decode_if  dec ();

    mips_regfile mips_regfile_i (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rd         (rf_rd.regfile),
        .wb_we_i    (wb_we_i),
        .wb_waddr_i (wb_waddr_i),
        .wb_wdata_i (wb_wdata_i)
    );

    mips_decoder mips_decoder_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .rd           (rf_rd.decoder),
        .dec          (dec.decoder)
    );

    mips_operand_stage mips_operand_stage_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .dec            (dec.operand),
        .rd1_data_i     (rf_rd.rd1_data),
        .rd2_data_i     (rf_rd.rd2_data),
        .ex_wreg_i      (ex_wreg_i),
        .ex_wd_i        (ex_wd_i),
        .ex_wdata_i     (ex_wdata_i),
        .mem_wreg_i     (mem_wreg_i),
        .mem_wd_i       (mem_wd_i),
        .mem_wdata_i    (mem_wdata_i),
        .aluop_o        (aluop_o),
        .alusel_o       (alusel_o),
        .reg1_o         (reg1_o),
        .reg2_o         (reg2_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .inst_invalid_o (inst_invalid_o),
        .valid_o        (valid_o)
    );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2;  // 4 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

// ==== bench/tb_mips_id.sv ====
`timescale 1ns/1ns

module tb_mips_id;

    localparam int RESULT_TIMEOUT = 8;
    localparam int EXT_ZERO  = 0;
    localparam int EXT_SIGN  = 1;
    localparam int EXT_UPPER = 2;

    logic                            clk;
    logic                            arst_n;
    logic [mips_isa_pkg::INST_W-1:0] inst;
    logic                            inst_valid;
    logic                            wb_we;
    mips_ctrl_pkg::reg_addr_t        wb_waddr;
    mips_ctrl_pkg::word_t            wb_wdata;
    logic                            ex_wreg;
    mips_ctrl_pkg::reg_addr_t        ex_wd;
    mips_ctrl_pkg::word_t            ex_wdata;
    logic                            mem_wreg;
    mips_ctrl_pkg::reg_addr_t        mem_wd;
    mips_ctrl_pkg::word_t            mem_wdata;
    mips_ctrl_pkg::alu_op_e          aluop;
    mips_ctrl_pkg::alu_sel_e         alusel;
    mips_ctrl_pkg::word_t            reg1;
    mips_ctrl_pkg::word_t            reg2;
    mips_ctrl_pkg::reg_addr_t        wd;
    logic                            wreg;
    logic                            inst_invalid;
    logic                            valid;

    mips_ctrl_pkg::word_t mirror [32];  // expected register file contents
    logic [31:0]          lcg_state;
    int                   checks;
    int                   errors;
    int                   tests;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    mips_id_top mips_id_top_i (
        .clk_i          (clk),
        .arst_n_i       (arst_n),
        .inst_i         (inst),
        .inst_valid_i   (inst_valid),
        .wb_we_i        (wb_we),
        .wb_waddr_i     (wb_waddr),
        .wb_wdata_i     (wb_wdata),
        .ex_wreg_i      (ex_wreg),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_wreg_i     (mem_wreg),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .aluop_o        (aluop),
        .alusel_o       (alusel),
        .reg1_o         (reg1),
        .reg2_o         (reg2),
        .wd_o           (wd),
        .wreg_o         (wreg),
        .inst_invalid_o (inst_invalid),
        .valid_o        (valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic mips_ctrl_pkg::reg_addr_t rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return r[31:27];  // upper bits, low LCG bits are weak
    endfunction

    function automatic logic [31:0] r_inst(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] shamt,
                                           input logic [5:0] fn);
        return {mips_isa_pkg::OP_SPECIAL, rs, rt, rd, shamt, fn};
    endfunction

    // ALU operation expected for each kept SPECIAL function code
    function automatic mips_ctrl_pkg::alu_op_e op_for_funct(input logic [5:0] fn);
        case (fn)
            mips_isa_pkg::FN_OR:   return mips_ctrl_pkg::ALU_OR;
            mips_isa_pkg::FN_AND:  return mips_ctrl_pkg::ALU_AND;
            mips_isa_pkg::FN_XOR:  return mips_ctrl_pkg::ALU_XOR;
            mips_isa_pkg::FN_NOR:  return mips_ctrl_pkg::ALU_NOR;
            mips_isa_pkg::FN_SLLV: return mips_ctrl_pkg::ALU_SLL;
            mips_isa_pkg::FN_SRLV: return mips_ctrl_pkg::ALU_SRL;
            mips_isa_pkg::FN_SRAV: return mips_ctrl_pkg::ALU_SRA;
            mips_isa_pkg::FN_SLT:  return mips_ctrl_pkg::ALU_SLT;
            mips_isa_pkg::FN_SLTU: return mips_ctrl_pkg::ALU_SLTU;
            mips_isa_pkg::FN_ADD:  return mips_ctrl_pkg::ALU_ADD;
            mips_isa_pkg::FN_ADDU: return mips_ctrl_pkg::ALU_ADDU;
            mips_isa_pkg::FN_SUB:  return mips_ctrl_pkg::ALU_SUB;
            mips_isa_pkg::FN_SUBU: return mips_ctrl_pkg::ALU_SUBU;
            default:               return mips_ctrl_pkg::ALU_NOP;
        endcase
    endfunction

    function automatic mips_ctrl_pkg::alu_sel_e class_of(input mips_ctrl_pkg::alu_op_e op);
        if (op == mips_ctrl_pkg::ALU_NOP) begin
            return mips_ctrl_pkg::SEL_NOP;
        end
        if (op inside {mips_ctrl_pkg::ALU_OR, mips_ctrl_pkg::ALU_AND,
                       mips_ctrl_pkg::ALU_XOR, mips_ctrl_pkg::ALU_NOR}) begin
            return mips_ctrl_pkg::SEL_LOGIC;
        end
        if (op inside {mips_ctrl_pkg::ALU_SLL, mips_ctrl_pkg::ALU_SRL,
                       mips_ctrl_pkg::ALU_SRA}) begin
            return mips_ctrl_pkg::SEL_SHIFT;
        end
        return mips_ctrl_pkg::SEL_ARITH;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flags(input logic v, input logic inv, input logic w);
        check_eq("valid_o", valid, v);
        check_eq("inst_invalid_o", inst_invalid, inv);
        check_eq("wreg_o", wreg, w);
    endtask

    task automatic check_result(input mips_ctrl_pkg::alu_op_e op, input mips_ctrl_pkg::word_t r1,
                                input mips_ctrl_pkg::word_t r2, input logic [4:0] dst);
        check_flags(1'b1, 1'b0, 1'b1);
        check_eq("aluop_o", aluop, op);
        check_eq("alusel_o", alusel, class_of(op));
        check_eq("reg1_o", reg1, r1);
        check_eq("reg2_o", reg2, r2);
        check_eq("wd_o", wd, dst);
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        tests++;
        $display("%-10s %s, %0d mismatches", name,
                 (errors == errs_at_start) ? "passed" : "failed", errors - errs_at_start);
    endtask

    task automatic write_reg(input logic [4:0] addr, input mips_ctrl_pkg::word_t data);
        @(posedge clk);
        wb_we    <= 1'b1;
        wb_waddr <= addr;
        wb_wdata <= data;
        if (addr != 5'd0) begin
            mirror[addr] = data;  // r0 stays zero
        end
        @(posedge clk);
        wb_we <= 1'b0;
    endtask

    // returns right after the capture edge, side inputs go in here
    task automatic send_inst(input logic [31:0] word);
        @(posedge clk);
        inst       <= word;
        inst_valid <= 1'b1;
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    task automatic await_result();
        int   cycles;
        logic got;
        cycles = 1;
        got    = 1'b0;
        while (!got && cycles < RESULT_TIMEOUT) begin
            @(posedge clk);
            cycles++;
            wb_we    <= 1'b0;
            ex_wreg  <= 1'b0;
            mem_wreg <= 1'b0;
            @(negedge clk);
            got = valid;
        end
        if (!got) begin
            errors++;
            $display("timeout at %0t ns: valid_o did not rise after an instruction", $time);
        end else begin
            check_eq("latency", cycles, 2);
        end
    endtask

    task automatic test_reset();
        int errs;
        errs = errors;
        @(posedge clk);
        @(negedge clk);
        check_flags(1'b0, 1'b0, 1'b0);
        check_eq("aluop_o", aluop, mips_ctrl_pkg::ALU_NOP);
        check_eq("alusel_o", alusel, mips_ctrl_pkg::SEL_NOP);
        check_eq("reg1_o", reg1, 32'h0);
        check_eq("reg2_o", reg2, 32'h0);
        check_eq("wd_o", wd, 32'h0);
        finish_test("reset", errs);
    endtask

    task automatic test_rtype();
        int         errs;
        logic [5:0] fns [13];
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        errs = errors;
        fns = '{mips_isa_pkg::FN_OR, mips_isa_pkg::FN_AND, mips_isa_pkg::FN_XOR,
                mips_isa_pkg::FN_NOR, mips_isa_pkg::FN_SLLV, mips_isa_pkg::FN_SRLV,
                mips_isa_pkg::FN_SRAV, mips_isa_pkg::FN_SLT, mips_isa_pkg::FN_SLTU,
                mips_isa_pkg::FN_ADD, mips_isa_pkg::FN_ADDU, mips_isa_pkg::FN_SUB,
                mips_isa_pkg::FN_SUBU};
        for (int i = 1; i < 32; i++) begin
            write_reg(i[4:0], lcg_next());
        end
        for (int i = 0; i < 13; i++) begin
            rs = rand_reg();
            rt = rand_reg();
            rd = rand_reg();
            send_inst(r_inst(rs, rt, rd, 5'd0, fns[i]));
            await_result();
            check_result(op_for_funct(fns[i]), mirror[rs], mirror[rt], rd);
        end
        finish_test("rtype", errs);
    endtask

    task automatic run_imm(input logic [5:0] op, input mips_ctrl_pkg::alu_op_e exp_op,
                           input int ext);
        logic [4:0]           rs;
        logic [4:0]           rt;
        logic [31:0]          r;
        logic [15:0]          imm16;
        mips_ctrl_pkg::word_t exp_imm;
        rs = rand_reg();
        rt = rand_reg();
        r  = lcg_next();
        imm16 = r[31:16];
        if (ext == EXT_SIGN) begin
            imm16[15] = 1'b1;  // make the extension visible
        end
        case (ext)
            EXT_ZERO: exp_imm = {16'h0000, imm16};
            EXT_SIGN: exp_imm = {{16{imm16[15]}}, imm16};
            default:  exp_imm = {imm16, 16'h0000};
        endcase
        send_inst({op, rs, rt, imm16});
        await_result();
        check_result(exp_op, mirror[rs], exp_imm, rt);
    endtask

    task automatic run_shift(input logic [5:0] fn, input mips_ctrl_pkg::alu_op_e exp_op);
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] r;
        rt = rand_reg();
        rd = rand_reg();
        r  = lcg_next();
        send_inst(r_inst(5'd0, rt, rd, r[31:27], fn));
        await_result();
        check_result(exp_op, {27'd0, r[31:27]}, mirror[rt], rd);
    endtask

    task automatic test_imm();
        int errs;
        errs = errors;
        run_imm(mips_isa_pkg::OP_ORI, mips_ctrl_pkg::ALU_OR, EXT_ZERO);
        run_imm(mips_isa_pkg::OP_ANDI, mips_ctrl_pkg::ALU_AND, EXT_ZERO);
        run_imm(mips_isa_pkg::OP_XORI, mips_ctrl_pkg::ALU_XOR, EXT_ZERO);
        run_imm(mips_isa_pkg::OP_ADDI, mips_ctrl_pkg::ALU_ADDI, EXT_SIGN);
        run_imm(mips_isa_pkg::OP_ADDIU, mips_ctrl_pkg::ALU_ADDIU, EXT_SIGN);
        run_imm(mips_isa_pkg::OP_SLTI, mips_ctrl_pkg::ALU_SLT, EXT_SIGN);
        run_imm(mips_isa_pkg::OP_SLTIU, mips_ctrl_pkg::ALU_SLTU, EXT_SIGN);
        run_imm(mips_isa_pkg::OP_LUI, mips_ctrl_pkg::ALU_OR, EXT_UPPER);
        run_shift(mips_isa_pkg::FN_SLL, mips_ctrl_pkg::ALU_SLL);
        run_shift(mips_isa_pkg::FN_SRL, mips_ctrl_pkg::ALU_SRL);
        run_shift(mips_isa_pkg::FN_SRA, mips_ctrl_pkg::ALU_SRA);
        finish_test("immediate", errs);
    endtask

    task automatic test_forward();
        int                   errs;
        mips_ctrl_pkg::word_t fx;
        mips_ctrl_pkg::word_t fm;
        errs = errors;
        fx = lcg_next();
        fm = lcg_next();
        send_inst(r_inst(5'd5, 5'd9, 5'd3, 5'd0, mips_isa_pkg::FN_OR));
        ex_wreg   <= 1'b1;
        ex_wd     <= 5'd5;
        ex_wdata  <= fx;
        mem_wreg  <= 1'b1;
        mem_wd    <= 5'd5;
        mem_wdata <= fm;
        await_result();
        check_eq("reg1_o", reg1, fx);  // execute wins
        check_eq("reg2_o", reg2, mirror[9]);
        send_inst(r_inst(5'd5, 5'd9, 5'd3, 5'd0, mips_isa_pkg::FN_OR));
        mem_wreg  <= 1'b1;
        mem_wd    <= 5'd5;
        mem_wdata <= fm;
        await_result();
        check_eq("reg1_o", reg1, fm);
        finish_test("forward", errs);
    endtask

    task automatic test_regfile();
        int                   errs;
        mips_ctrl_pkg::word_t d;
        errs = errors;
        d = lcg_next();
        send_inst(r_inst(5'd7, 5'd8, 5'd2, 5'd0, mips_isa_pkg::FN_ADDU));
        wb_we    <= 1'b1;  // lands in the read cycle
        wb_waddr <= 5'd7;
        wb_wdata <= d;
        await_result();
        mirror[7] = d;
        check_eq("reg1_o", reg1, d);
        check_eq("reg2_o", reg2, mirror[8]);
        write_reg(5'd0, lcg_next());
        d = lcg_next();
        send_inst(r_inst(5'd0, 5'd0, 5'd2, 5'd0, mips_isa_pkg::FN_OR));
        wb_we    <= 1'b1;
        wb_waddr <= 5'd0;
        wb_wdata <= d;
        await_result();
        check_eq("reg1_o", reg1, 32'h0);
        check_eq("reg2_o", reg2, 32'h0);
        finish_test("regfile", errs);
    endtask

    task automatic test_invalid();
        int          errs;
        logic [31:0] r;
        errs = errors;
        r = lcg_next();
        send_inst({6'b111111, r[25:0]});  // no such opcode
        await_result();
        check_flags(1'b1, 1'b1, 1'b0);
        send_inst(r_inst(rand_reg(), rand_reg(), 5'd0, 5'd0, 6'b011000));  // MULT
        await_result();
        check_flags(1'b1, 1'b1, 1'b0);
        send_inst(r_inst(5'd0, 5'd0, 5'd0, 5'd0, mips_isa_pkg::FN_SYNC));
        await_result();
        check_flags(1'b1, 1'b0, 1'b0);
        finish_test("invalid", errs);
    endtask

    initial begin
        arst_n     = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        wb_we      = 1'b0;
        wb_waddr   = '0;
        wb_wdata   = '0;
        ex_wreg    = 1'b0;
        ex_wd      = '0;
        ex_wdata   = '0;
        mem_wreg   = 1'b0;
        mem_wd     = '0;
        mem_wdata  = '0;
        lcg_state  = 32'h9362_8b39;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        for (int i = 0; i < 32; i++) begin
            mirror[i] = '0;
        end
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_rtype();
        test_imm();
        test_forward();
        test_regfile();
        test_invalid();
        $display("%0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
verilog/mips_isa_pkg.sv
verilog/mips_ctrl_pkg.sv
verilog/decode_if.sv
verilog/rf_read_if.sv
verilog/mips_regfile.sv
verilog/mips_decoder.sv
verilog/mips_operand_stage.sv
verilog/mips_id_top.sv
bench/tb_clock_gen.sv
bench/tb_mips_id.sv
